/* logic/mapper_pkg.sv */
`default_nettype none

package mapper_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus and bank widths.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [14:0] cpu_addr_t;  // CPU address below A15.
	typedef logic [13:0] ppu_addr_t;
	typedef logic [18:0] prg_addr_t;  // 512 KB of PRG ROM.
	typedef logic [18:0] chr_addr_t;
	typedef logic [7:0]  bank_t;
	typedef logic [5:0]  prg_bank_t;  // Counted in 8 KB units.
	typedef logic [2:0]  reg_sel_t;   // {A14, A13, A0} of a mapper write.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control register indices, $8000 through $E001.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam reg_sel_t reg_cfg         = 3'd0;
	localparam reg_sel_t reg_bank_data   = 3'd1;  // Lands in the bank picked by reg_cfg.
	localparam reg_sel_t reg_mirror      = 3'd2;
	localparam reg_sel_t reg_ram_cfg     = 3'd3;
	localparam reg_sel_t reg_reload      = 3'd4;
	localparam reg_sel_t reg_irq_clear   = 3'd5;  // Asks for a reload on the next clock.
	localparam reg_sel_t reg_irq_disable = 3'd6;
	localparam reg_sel_t reg_irq_enable  = 3'd7;

	// Bit positions inside the control and extended registers.
	localparam int cfg_swap_bit   = 6;
	localparam int cfg_invert_bit = 7;
	localparam int ram_enable_bit = 7;
	localparam int ext_outer_bit  = 7;
	localparam int ext_chr_hi_bit = 4;

	// A14:13 of the $6000-$7FFF window.
	localparam logic [1:0] ram_window = 2'b11;

	localparam bank_t bank_reset_values [0:7] = '{
		8'd0, 8'd2, 8'd4, 8'd5, 8'd6, 8'd7, 8'd0, 8'd1
	};

	localparam prg_bank_t prg_fixed_last        = 6'h3F;
	localparam prg_bank_t prg_fixed_second_last = 6'h3E;

	localparam int a12_quiet_cycles = 4;  // Low samples needed before a rise counts.

endpackage

`default_nettype wire

/* logic/save_state_pkg.sv */
`default_nettype none

package save_state_pkg;

	typedef logic [7:0] ss_addr_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Save-state address map.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam ss_addr_t ss_ctrl_base = 8'd0;   // Eight control registers.
	localparam ss_addr_t ss_bank_base = 8'd8;   // Eight bank registers.
	localparam ss_addr_t ss_irq_ctr   = 8'd16;
	localparam ss_addr_t ss_irq_flags = 8'd17;
	localparam ss_addr_t ss_ext       = 8'd18;
	localparam ss_addr_t ss_map_idx   = 8'd127;

	// The loader checks this number before it restores anything.
	localparam logic [7:0] map_idx_value = 8'd115;

	localparam logic [7:0] ss_unmapped_value = 8'hFF;

endpackage

`default_nettype wire

/* logic/mapper_regs_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mapper_regs_if;

	// Mapping state for the bank translator.
	logic                  swap_control;
	logic                  chr_invert;
	logic                  mirror_mode;
	mapper_pkg::bank_t     chr_banks [0:5];
	mapper_pkg::prg_bank_t prg_banks [0:1];
	logic [7:0]            ext;

	// Counter setup and one-edge strobes.
	logic [7:0] reload_value;
	logic       mmc3b_mode;
	logic       reload_req_set;
	logic       irq_disable;    // Also acknowledges a pending interrupt.
	logic       irq_enable;
	logic       ss_flags_we;
	logic       ss_ctr_we;
	logic [7:0] ss_wdata;

	// Counter state returned for save-state reads.
	logic [7:0] irq_ctr;
	logic [7:0] irq_flags;

	modport regs (
		output swap_control, chr_invert, mirror_mode, chr_banks, prg_banks, ext,
		output reload_value, mmc3b_mode,
		output reload_req_set, irq_disable, irq_enable, ss_flags_we, ss_ctr_we, ss_wdata,
		input  irq_ctr, irq_flags
	);

	modport banks (
		input swap_control, chr_invert, mirror_mode, chr_banks, prg_banks, ext
	);

	modport irq (
		input  reload_value, mmc3b_mode,
		input  reload_req_set, irq_disable, irq_enable, ss_flags_we, ss_ctr_we, ss_wdata,
		output irq_ctr, irq_flags
	);

endinterface

`default_nettype wire

/* logic/mapper_115_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mapper_115_regs (
	input  wire logic                     m2,
	input  wire logic                     map_rst,
	input  wire mapper_pkg::cpu_addr_t    cpu_addr,
	input  wire logic [7:0]               cpu_dat,
	input  wire logic                     cpu_ce,
	input  wire logic                     cpu_rw,
	input  wire logic                     cfg_mir_v,
	input  wire logic                     cfg_mmc3b,
	input  wire logic                     ss_act,
	input  wire logic                     ss_we,
	input  wire save_state_pkg::ss_addr_t ss_addr,
	output logic [7:0]                    ss_rdat,
	output logic                          map_cpu_oe,
	mapper_regs_if.regs                   regs
);

	logic [7:0]           ctrl_regs [0:7];
	mapper_pkg::bank_t    bank_regs [0:7];
	logic [7:0]           ext;
	mapper_pkg::reg_sel_t reg_sel;
	logic                 map_wr;
	logic                 ram_area;
	logic                 ext_wr;

	assign reg_sel  = {cpu_addr[14], cpu_addr[13], cpu_addr[0]};
	assign map_wr   = !cpu_ce && !cpu_rw && !ss_act;
	assign ram_area = cpu_ce && cpu_addr[14:13] == mapper_pkg::ram_window;
	assign ext_wr   = ram_area && !cpu_rw && !ss_act;

	// With the RAM off, reads of the window float to open bus.
	assign map_cpu_oe = ram_area && cpu_rw &&
		!ctrl_regs[mapper_pkg::reg_ram_cfg][mapper_pkg::ram_enable_bit];

	always_ff @(negedge m2)
	begin
		if (map_rst)
		begin
			for (int i = 0; i < 8; i++)
			begin
				ctrl_regs[i] <= '0;
				bank_regs[i] <= mapper_pkg::bank_reset_values[i];
			end
			ctrl_regs[mapper_pkg::reg_mirror] <= {7'd0, cfg_mir_v};
			ext <= '0;
		end
		else if (ss_act)
		begin
			if (ss_we && ss_addr[7:3] == save_state_pkg::ss_ctrl_base[7:3])
				ctrl_regs[ss_addr[2:0]] <= cpu_dat;
			if (ss_we && ss_addr[7:3] == save_state_pkg::ss_bank_base[7:3])
				bank_regs[ss_addr[2:0]] <= cpu_dat;
			if (ss_we && ss_addr == save_state_pkg::ss_ext)
				ext <= cpu_dat;
		end
		else
		begin
			if (map_wr)
			begin
				ctrl_regs[reg_sel] <= cpu_dat;
				if (reg_sel == mapper_pkg::reg_bank_data)
					bank_regs[ctrl_regs[mapper_pkg::reg_cfg][2:0]] <= cpu_dat;
			end
			// Even addresses carry the outer bank, odd ones the CHR high bit.
			if (ext_wr)
			begin
				if (!cpu_addr[0])
				begin
					ext[3:0] <= cpu_dat[3:0];
					ext[7]   <= cpu_dat[7];
				end
				else
					ext[mapper_pkg::ext_chr_hi_bit] <= cpu_dat[0];
			end
		end
	end

	always_comb
	begin
		ss_rdat = save_state_pkg::ss_unmapped_value;
		if (ss_addr[7:3] == save_state_pkg::ss_ctrl_base[7:3])
			ss_rdat = ctrl_regs[ss_addr[2:0]];
		else if (ss_addr[7:3] == save_state_pkg::ss_bank_base[7:3])
			ss_rdat = bank_regs[ss_addr[2:0]];
		else if (ss_addr == save_state_pkg::ss_irq_ctr)
			ss_rdat = regs.irq_ctr;
		else if (ss_addr == save_state_pkg::ss_irq_flags)
			ss_rdat = regs.irq_flags;
		else if (ss_addr == save_state_pkg::ss_ext)
			ss_rdat = ext;
		else if (ss_addr == save_state_pkg::ss_map_idx)
			ss_rdat = save_state_pkg::map_idx_value;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fields handed to the translator and the counter.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign regs.swap_control = ctrl_regs[mapper_pkg::reg_cfg][mapper_pkg::cfg_swap_bit];
	assign regs.chr_invert   = ctrl_regs[mapper_pkg::reg_cfg][mapper_pkg::cfg_invert_bit];
	assign regs.mirror_mode  = ctrl_regs[mapper_pkg::reg_mirror][0];
	assign regs.ext          = ext;

	for (genvar i = 0; i < 6; i++)
	begin : g_chr_banks
		assign regs.chr_banks[i] = bank_regs[i];
	end

	assign regs.prg_banks[0] = bank_regs[6][5:0];  // Swappable $8000 or $C000 slot.
	assign regs.prg_banks[1] = bank_regs[7][5:0];

	assign regs.reload_value = ctrl_regs[mapper_pkg::reg_reload];
	assign regs.mmc3b_mode   = cfg_mmc3b;

	assign regs.reload_req_set = map_wr && reg_sel == mapper_pkg::reg_irq_clear;
	assign regs.irq_disable    = map_wr && reg_sel == mapper_pkg::reg_irq_disable;
	assign regs.irq_enable     = map_wr && reg_sel == mapper_pkg::reg_irq_enable;
	assign regs.ss_flags_we    = ss_act && ss_we && ss_addr == save_state_pkg::ss_irq_flags;
	assign regs.ss_ctr_we      = ss_act && ss_we && ss_addr == save_state_pkg::ss_irq_ctr;
	assign regs.ss_wdata       = cpu_dat;

endmodule

`default_nettype wire

/* logic/mapper_115_banks.sv */
`timescale 1ns/1ps
`default_nettype none

module mapper_115_banks (
	input  wire mapper_pkg::cpu_addr_t cpu_addr,
	input  wire logic                  cpu_ce,
	input  wire mapper_pkg::ppu_addr_t ppu_addr,
	input  wire logic                  ppu_we,
	input  wire logic                  cfg_chr_ram,
	output mapper_pkg::prg_addr_t      prg_addr,
	output mapper_pkg::chr_addr_t      chr_addr,
	output logic                       rom_ce,
	output logic                       chr_ce,
	output logic                       chr_we,
	output logic                       ciram_a10,
	output logic                       ciram_ce,
	mapper_regs_if.banks               banks
);

	mapper_pkg::prg_bank_t prg_bank;
	mapper_pkg::bank_t     chr_bank;
	mapper_pkg::bank_t     chr_page;  // 1 KB page after the CHR RAM mask.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// PRG.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		if (cpu_ce)
			prg_bank = '0;
		else if (banks.ext[mapper_pkg::ext_outer_bit])
			prg_bank = {1'b0, banks.ext[3:1], cpu_addr[14:13]};  // 32 KB outer bank.
		else
		begin
			case (cpu_addr[14:13])
				2'd0: prg_bank = banks.swap_control ?
					mapper_pkg::prg_fixed_second_last : banks.prg_banks[0];
				2'd1: prg_bank = banks.prg_banks[1];
				2'd2: prg_bank = banks.swap_control ?
					banks.prg_banks[0] : mapper_pkg::prg_fixed_second_last;
				default: prg_bank = mapper_pkg::prg_fixed_last;
			endcase
		end
	end

	assign prg_addr = {prg_bank, cpu_addr[12:0]};
	assign rom_ce   = !cpu_ce;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CHR and nametables.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// The 2 KB banks sit in the half chosen by chr_invert.
	always_comb
	begin
		if (ppu_addr[12:11] == {banks.chr_invert, 1'b0})
			chr_bank = {banks.chr_banks[0][7:1], ppu_addr[10]};
		else if (ppu_addr[12:11] == {banks.chr_invert, 1'b1})
			chr_bank = {banks.chr_banks[1][7:1], ppu_addr[10]};
		else
		begin
			case (ppu_addr[11:10])
				2'd0: chr_bank = banks.chr_banks[2];
				2'd1: chr_bank = banks.chr_banks[3];
				2'd2: chr_bank = banks.chr_banks[4];
				default: chr_bank = banks.chr_banks[5];
			endcase
		end
	end

	assign chr_page = cfg_chr_ram ? {5'd0, chr_bank[2:0]} : chr_bank;
	assign chr_addr = {banks.ext[mapper_pkg::ext_chr_hi_bit] && !cfg_chr_ram,
		chr_page, ppu_addr[9:0]};

	assign chr_ce = !ppu_addr[13];
	assign chr_we = cfg_chr_ram && !ppu_we && chr_ce;

	assign ciram_a10 = banks.mirror_mode ? ppu_addr[11] : ppu_addr[10];
	assign ciram_ce  = ppu_addr[13];  // Nametables live at $2000 and up.

endmodule

`default_nettype wire

/* logic/scanline_irq.sv */
`timescale 1ns/1ps
`default_nettype none

module scanline_irq (
	input  wire logic                  m2,
	input  wire logic                  map_rst,
	input  wire mapper_pkg::ppu_addr_t ppu_addr,
	input  wire logic                  ss_act,
	output logic                       irq,
	mapper_regs_if.irq                 ctl
);

	localparam int hist_msb = mapper_pkg::a12_quiet_cycles - 1;

	logic [hist_msb:0] a12_hist;  // Newest sample in bit 0.
	logic [7:0]        irq_ctr;
	logic [7:0]        ctr_next;
	logic              irq_on;
	logic              irq_pend;
	logic              reload_req;
	logic              a12_clk;
	logic              reload;
	logic              irq_fire;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Counter clock and next value.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Short A12 blips during sprite fetches never reach this.
	assign a12_clk = ppu_addr[12] && a12_hist == '0 && !ss_act;

	assign reload   = reload_req || (ctl.mmc3b_mode && irq_ctr == 8'd0);
	assign ctr_next = (reload || irq_ctr == 8'd0) ? ctl.reload_value : irq_ctr - 8'd1;

	// On the older chip an automatic reload from zero stays silent.
	assign irq_fire = a12_clk && irq_on && ctr_next == 8'd0 &&
		(reload || irq_ctr != 8'd0);

	assign irq = irq_pend || irq_fire;

	always_ff @(negedge m2)
	begin
		if (map_rst)
		begin
			a12_hist   <= '0;
			irq_ctr    <= '0;
			irq_on     <= 1'b0;
			irq_pend   <= 1'b0;
			reload_req <= 1'b0;
		end
		else if (ss_act)
		begin
			// Each flag is stored as a pair, set when the two bits differ.
			if (ctl.ss_flags_we)
			begin
				reload_req <= ctl.ss_wdata[1] ^ ctl.ss_wdata[0];
				irq_pend   <= ctl.ss_wdata[3] ^ ctl.ss_wdata[2];
				irq_on     <= ctl.ss_wdata[4];
			end
			if (ctl.ss_ctr_we)
				irq_ctr <= ctl.ss_wdata;
		end
		else
		begin
			a12_hist <= {a12_hist[hist_msb-1:0], ppu_addr[12]};

			if (a12_clk)
			begin
				irq_ctr    <= ctr_next;
				reload_req <= 1'b0;
				if (irq_fire)
					irq_pend <= 1'b1;
			end

			if (ctl.reload_req_set)
				reload_req <= 1'b1;
			if (ctl.irq_disable)
			begin
				irq_on   <= 1'b0;
				irq_pend <= 1'b0;  // Acknowledge.
			end
			if (ctl.irq_enable)
				irq_on <= 1'b1;
		end
	end

	assign ctl.irq_ctr   = irq_ctr;
	assign ctl.irq_flags = {3'b000, irq_on, irq_pend, 1'b0, reload_req, 1'b0};

endmodule

`default_nettype wire

/* logic/mapper_115.sv */
`timescale 1ns/1ps
`default_nettype none

module mapper_115 (
	input  wire logic                     m2,
	input  wire logic                     map_rst,
	input  wire mapper_pkg::cpu_addr_t    cpu_addr,
	input  wire logic [7:0]               cpu_dat,
	input  wire logic                     cpu_ce,
	input  wire logic                     cpu_rw,
	input  wire mapper_pkg::ppu_addr_t    ppu_addr,
	input  wire logic                     ppu_we,
	input  wire logic                     cfg_chr_ram,
	input  wire logic                     cfg_mir_v,
	input  wire logic                     cfg_mmc3b,
	input  wire logic                     ss_act,
	input  wire logic                     ss_we,
	input  wire save_state_pkg::ss_addr_t ss_addr,
	output mapper_pkg::prg_addr_t         prg_addr,
	output mapper_pkg::chr_addr_t         chr_addr,
	output logic                          rom_ce,
	output logic                          chr_ce,
	output logic                          chr_we,
	output logic                          ciram_a10,
	output logic                          ciram_ce,
	output logic                          map_cpu_oe,
	output logic                          irq,
	output logic [7:0]                    ss_rdat
);

	mapper_regs_if regs_bus ();

	mapper_115_regs u_regs (
		.m2         (m2),
		.map_rst    (map_rst),
		.cpu_addr   (cpu_addr),
		.cpu_dat    (cpu_dat),
		.cpu_ce     (cpu_ce),
		.cpu_rw     (cpu_rw),
		.cfg_mir_v  (cfg_mir_v),
		.cfg_mmc3b  (cfg_mmc3b),
		.ss_act     (ss_act),
		.ss_we      (ss_we),
		.ss_addr    (ss_addr),
		.ss_rdat    (ss_rdat),
		.map_cpu_oe (map_cpu_oe),
		.regs       (regs_bus)
	);

	// Pure address logic, no clock.
	mapper_115_banks u_banks (
		.cpu_addr    (cpu_addr),
		.cpu_ce      (cpu_ce),
		.ppu_addr    (ppu_addr),
		.ppu_we      (ppu_we),
		.cfg_chr_ram (cfg_chr_ram),
		.prg_addr    (prg_addr),
		.chr_addr    (chr_addr),
		.rom_ce      (rom_ce),
		.chr_ce      (chr_ce),
		.chr_we      (chr_we),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce),
		.banks       (regs_bus)
	);

	scanline_irq u_irq (
		.m2       (m2),
		.map_rst  (map_rst),
		.ppu_addr (ppu_addr),
		.ss_act   (ss_act),
		.irq      (irq),
		.ctl      (regs_bus)
	);

endmodule

`default_nettype wire

/* dv/mapper_115_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mapper_115_tb;

	localparam int max_ops     = 64;
	localparam int cycle_limit = 20000;  // Whole run, in m2 cycles.

	logic                     m2;
	logic                     map_rst;
	mapper_pkg::cpu_addr_t    cpu_addr;
	logic [7:0]               cpu_dat;
	logic                     cpu_ce;
	logic                     cpu_rw;
	mapper_pkg::ppu_addr_t    ppu_addr;
	logic                     ppu_we;
	logic                     cfg_chr_ram;
	logic                     cfg_mir_v;
	logic                     cfg_mmc3b;
	logic                     ss_act;
	logic                     ss_we;
	save_state_pkg::ss_addr_t ss_addr;
	mapper_pkg::prg_addr_t    prg_addr;
	mapper_pkg::chr_addr_t    chr_addr;
	logic                     rom_ce;
	logic                     chr_ce;
	logic                     chr_we;
	logic                     ciram_a10;
	logic                     ciram_ce;
	logic                     map_cpu_oe;
	logic                     irq;
	logic [7:0]               ss_rdat;

	logic [19:0] patterns [0:4*max_ops-1];  // Four words per operation.
	integer      seed;
	logic        ram_en;  // RAM enable bit of register 3 as last written.

	mapper_115 DUT (
		.m2          (m2),
		.map_rst     (map_rst),
		.cpu_addr    (cpu_addr),
		.cpu_dat     (cpu_dat),
		.cpu_ce      (cpu_ce),
		.cpu_rw      (cpu_rw),
		.ppu_addr    (ppu_addr),
		.ppu_we      (ppu_we),
		.cfg_chr_ram (cfg_chr_ram),
		.cfg_mir_v   (cfg_mir_v),
		.cfg_mmc3b   (cfg_mmc3b),
		.ss_act      (ss_act),
		.ss_we       (ss_we),
		.ss_addr     (ss_addr),
		.prg_addr    (prg_addr),
		.chr_addr    (chr_addr),
		.rom_ce      (rom_ce),
		.chr_ce      (chr_ce),
		.chr_we      (chr_we),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce),
		.map_cpu_oe  (map_cpu_oe),
		.irq         (irq),
		.ss_rdat     (ss_rdat)
	);

	initial
	begin
		m2 = 1'b0;
		forever #50 m2 = ~m2;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reporting and bus cycles.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input logic [31:0] want,
		input logic [31:0] got);
		if (got !== want)
			abort_run($sformatf("mismatch %s expected %h actual %h", name, want, got));
	endtask

	// Opens a cycle on the rising edge with the bus parked. Callers override fields.
	task automatic begin_cycle();
		@(posedge m2);
		cpu_addr    <= '0;
		cpu_dat     <= '0;
		cpu_ce      <= 1'b1;
		cpu_rw      <= 1'b1;
		ppu_addr    <= '0;
		ppu_we      <= 1'b1;
		cfg_chr_ram <= 1'b0;
		ss_act      <= 1'b0;
		ss_we       <= 1'b0;
		ss_addr     <= '0;
	endtask

	task automatic end_cycle();
		@(negedge m2);
		#1;  // Registered state has settled here.
	endtask

	task automatic a12_cycle(input logic high);
		begin_cycle();
		ppu_addr <= high ? 14'h1000 : 14'h0000;
		end_cycle();
	endtask

	// Long gaps give counted edges, short gaps only glitches after the first.
	task automatic pulse_a12(input int count, input logic short_gaps);
		int gap;
		if (short_gaps)
			repeat (mapper_pkg::a12_quiet_cycles) a12_cycle(1'b0);
		for (int k = 0; k < count; k++)
		begin
			if (short_gaps)
			begin
				a12_cycle(1'b1);
				gap = 1 + {$random(seed)} % 3;
				repeat (gap) a12_cycle(1'b0);
			end
			else
			begin
				gap = 4 + {$random(seed)} % 8;
				repeat (gap) a12_cycle(1'b0);
				a12_cycle(1'b1);
			end
		end
	endtask

	task automatic run_op(input int idx);
		logic [3:0]  op;
		logic [19:0] addr;
		logic [7:0]  data;
		logic [19:0] want;
		logic        oe_want;
		string       name;
		op   = patterns[4*idx][3:0];
		addr = patterns[4*idx+1];
		data = patterns[4*idx+2][7:0];
		want = patterns[4*idx+3];
		name = $sformatf("pattern %0d", idx);
		begin_cycle();
		case (op)
			4'h1, 4'h2:
			begin
				cpu_addr <= addr[14:0];
				cpu_dat  <= data;
				cpu_ce   <= (op == 4'h2);  // Extended register sits outside the ROM.
				cpu_rw   <= 1'b0;
			end
			4'h3:
				cpu_ce <= 1'b0;
			4'h7:
			begin
				// IRQ enable at $E001 first, so a glitch that got counted would raise irq.
				cpu_addr <= 15'h6001;
				cpu_ce   <= 1'b0;
				cpu_rw   <= 1'b0;
			end
			4'h8, 4'h9:
			begin
				ss_act  <= 1'b1;
				ss_we   <= (op == 4'h8);
				ss_addr <= addr[7:0];
				cpu_dat <= data;
			end
			default:
			begin
			end
		endcase
		if (op == 4'h3)
			cpu_addr <= addr[14:0];
		if (op == 4'h4 || op == 4'h5)
			ppu_addr <= addr[13:0];
		end_cycle();
		if (op == 4'h1 && {addr[14], addr[13], addr[0]} == mapper_pkg::reg_ram_cfg)
			ram_en = data[mapper_pkg::ram_enable_bit];
		if (op == 4'h8 &&
			addr[7:0] == save_state_pkg::ss_ctrl_base + mapper_pkg::reg_ram_cfg)
			ram_en = data[mapper_pkg::ram_enable_bit];
		case (op)
			4'h1, 4'h2, 4'h8:
			begin
			end
			4'h3:
			begin
				check_value({name, " prg_addr"}, want, prg_addr);
				check_value({name, " cpu enables"}, 2'b01, {map_cpu_oe, rom_ce});
				// Same address as a read below $8000, where only the RAM window answers.
				oe_want = addr[14:13] == 2'b11 && !ram_en;
				begin_cycle();
				cpu_addr <= addr[14:0];
				end_cycle();
				check_value({name, " cpu read enables"}, {oe_want, 1'b0},
					{map_cpu_oe, rom_ce});
			end
			4'h4:
			begin
				check_value({name, " chr_addr"}, want, chr_addr);
				check_value({name, " ppu enables"}, {addr[13], ~addr[13], 1'b0},
					{ciram_ce, chr_ce, chr_we});
				// CHR RAM keeps only 8 KB and takes PPU writes.
				begin_cycle();
				ppu_addr    <= addr[13:0];
				ppu_we      <= 1'b0;
				cfg_chr_ram <= 1'b1;
				end_cycle();
				check_value({name, " chr_addr in CHR RAM"}, {7'd0, want[12:0]}, chr_addr);
				check_value({name, " CHR RAM write enables"},
					{addr[13], ~addr[13], ~addr[13]}, {ciram_ce, chr_ce, chr_we});
			end
			4'h5:
			begin
				check_value({name, " ciram_a10"}, want, ciram_a10);
				check_value({name, " ppu enables"}, {addr[13], ~addr[13], 1'b0},
					{ciram_ce, chr_ce, chr_we});
			end
			4'h6, 4'h7:
			begin
				pulse_a12(data, op == 4'h7);
				check_value({name, " irq"}, want, irq);
			end
			4'h9: check_value({name, " ss_rdat"}, want, ss_rdat);
			4'hA: check_value({name, " irq"}, want, irq);
			default: abort_run($sformatf("%s has an unknown operation code %h", name, op));
		endcase
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pattern sequencer.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial
	begin
		#(cycle_limit * 100);
		abort_run("the run did not finish within its cycle limit");
	end

	initial
	begin
		int idx;
		seed        = 32'h39257ef8;
		ram_en      = 1'b0;
		map_rst     = 1'b1;
		cpu_addr    = '0;
		cpu_dat     = '0;
		cpu_ce      = 1'b1;
		cpu_rw      = 1'b1;
		ppu_addr    = '0;
		ppu_we      = 1'b1;
		cfg_chr_ram = 1'b0;
		cfg_mir_v   = 1'b0;
		cfg_mmc3b   = 1'b0;
		ss_act      = 1'b0;
		ss_we       = 1'b0;
		ss_addr     = '0;
		$readmemh("dv/mapper_115_patterns.txt", patterns);
		if (patterns[0] === 'x)
			abort_run("pattern file dv/mapper_115_patterns.txt could not be read");
		repeat (4) @(negedge m2);
		@(posedge m2);
		map_rst <= 1'b0;
		idx = 0;
		while (idx < max_ops && patterns[4*idx] !== 20'hF)
		begin
			run_op(idx);
			idx++;
		end
		if (idx == max_ops)
			abort_run("pattern list ran out without an end marker");
		else
		begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* dv/mapper_115_patterns.txt */
// op addr data expected. 1 mapper write, 2 ext write, 3 prg_addr, 4 chr_addr, 5 ciram_a10,
// 6 long A12 pulses, 7 short A12 pulses, 8 ss write, 9 ss read, A irq, F end.
3 6123 00 7E123
3 4456 00 7C456
4 0455 00 00455
A 0000 00 00000
1 0000 07 00000
1 0001 2A 00000
3 2020 00 54020
1 0000 C6 00000
1 0001 15 00000
3 4456 00 2A456
3 0010 00 7C010
1 0000 C0 00000
1 0001 21 00000
4 1455 00 08455
2 6000 85 00000
3 6123 00 16123
2 6001 01 00000
4 0455 00 41455
5 2400 00 00001
1 2000 01 00000
5 2400 00 00000
5 2800 00 00001
1 4000 03 00000
1 4001 00 00000
1 6001 00 00000
6 0000 03 00000
6 0000 01 00001
1 6000 00 00000
A 0000 00 00000
7 0000 04 00000
9 0010 00 00003
8 0008 5A 00000
9 0008 00 0005A
8 000F C3 00000
9 000F 00 000C3
8 0010 27 00000
9 0010 00 00027
8 0011 1A 00000
9 0011 00 0001A
8 0012 93 00000
9 0012 00 00093
9 007F 00 00073
9 0040 00 000FF
A 0000 00 00001
F 0000 00 00000

/* mapper_115.f */
logic/mapper_pkg.sv
logic/save_state_pkg.sv
logic/mapper_regs_if.sv
logic/mapper_115_regs.sv
logic/mapper_115_banks.sv
logic/scanline_irq.sv
logic/mapper_115.sv
dv/mapper_115_tb.sv

/* Bender.yml */
package:
  name: mapper_115

sources:
  - logic/mapper_pkg.sv
  - logic/save_state_pkg.sv
  - logic/mapper_regs_if.sv
  - logic/mapper_115_regs.sv
  - logic/mapper_115_banks.sv
  - logic/scanline_irq.sv
  - logic/mapper_115.sv
  - target: test
    files:
      - dv/mapper_115_tb.sv
